// ==== compile.f ====
+incdir+dv
hw/mat_alu_pkg.sv
hw/mat_elem_if.sv
hw/mat_op_ctrl.sv
hw/mat_elem_datapath.sv
hw/mat_stream_out.sv
hw/mat_alu_top.sv
dv/mat_alu_tb.sv

// ==== Makefile ====
# Verilator build and run for the matrix ALU testbench

VERILATOR ?= verilator
TOP       ?= mat_alu_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) dv/mat_alu_tests.svh

.PHONY: all run clean

all: run

# Rebuild only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/mat_alu_tests.svh ====
// Matrix ALU directed tests
// Reference model of the four operations, stream comparison and
// one task per checked behavior

  // ------------------------------------------------------------
  // Reference model and stimulus
  // ------------------------------------------------------------
  // Result cell (i,j) straight from the op definition
  function automatic longint ref_elem(input op_code_t op, input matrix_t a, input matrix_t b,
                                      input elem_t s, input int i, input int j);
    longint sum;
    int     k;
    sum = 0;
    case (op)
      OP_ADD:        sum = longint'(a.cells[i][j]) + longint'(b.cells[i][j]);
      OP_SCALAR_MUL: sum = longint'(a.cells[i][j]) * longint'(s);
      OP_TRANSPOSE:  sum = longint'(a.cells[j][i]);
      default: begin
        // Dot product of row i of A and column j of B
        for (k = 0; k < int'(a.cols); k++) begin
          sum += longint'(a.cells[i][k]) * longint'(b.cells[k][j]);
        end
      end
    endcase
    return sum;
  endfunction

  // Cell value depends on both row and column
  function automatic matrix_t make_matrix(input int rows, input int cols, input int base);
    matrix_t m;
    int      i;
    int      j;
    m      = '0;
    m.rows = dim_t'(rows);
    m.cols = dim_t'(cols);
    for (i = 0; i < rows; i++) begin
      for (j = 0; j < cols; j++) begin
        m.cells[i][j] = elem_t'(base + 13 * i - 7 * j + i * j);
      end
    end
    return m;
  endfunction

  function automatic matrix_t rand_matrix(input int rows, input int cols);
    matrix_t m;
    int      i;
    int      j;
    int      b;
    m      = '0;
    m.rows = dim_t'(rows);
    m.cols = dim_t'(cols);
    for (i = 0; i < rows; i++) begin
      for (j = 0; j < cols; j++) begin
        for (b = 0; b < ELEM_W; b++) begin
          m.cells[i][j] = {m.cells[i][j][ELEM_W-2:0], lfsr_bit()};
        end
      end
    end
    return m;
  endfunction

  // Count, values and last-column flags of the collected stream
  task automatic check_stream(input string name, input op_code_t op, input matrix_t a,
                              input matrix_t b, input elem_t s);
    int r;
    int c;
    int idx;
    r = (op == OP_TRANSPOSE) ? int'(a.cols) : int'(a.rows);
    c = (op == OP_TRANSPOSE) ? int'(a.rows) : (op == OP_MAT_MUL) ? int'(b.cols) : int'(a.cols);
    check_value({name, " element count"}, longint'(r * c), longint'(got_data.size()));
    for (idx = 0; idx < got_data.size() && idx < r * c; idx++) begin
      check_value($sformatf("%s element %0d", name, idx),
                  ref_elem(op, a, b, s, idx / c, idx % c), longint'(got_data[idx]));
      check_value($sformatf("%s last_col %0d", name, idx),
                  longint'(idx % c == c - 1), longint'(got_last[idx]));
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic check_after_reset();
    check_value("reset done", 0, longint'(done_o));
    check_value("reset error", 0, longint'(error_o));
    check_value("reset valid", 0, longint'(stream_valid_o));
  endtask

  task automatic add_3x2();
    matrix_t a;
    matrix_t b;
    a = make_matrix(3, 2, 10);
    b = make_matrix(3, 2, -40);
    run_op("add", OP_ADD, a, b, '0, 6);
    check_stream("add", OP_ADD, a, b, '0);
    check_value("add error", 0, longint'(error_o));
  endtask

  task automatic scale_and_transpose();
    matrix_t a;
    matrix_t b;
    // Extreme cells, products must not saturate
    a             = make_matrix(4, 4, 3);
    a.cells[0][0] = -8'sd128;
    a.cells[1][2] = 8'sd127;
    a.cells[2][1] = -8'sd128;
    a.cells[3][3] = 8'sd127;
    b             = '0;
    run_op("scale", OP_SCALAR_MUL, a, b, -8'sd128, 16);
    check_stream("scale", OP_SCALAR_MUL, a, b, -8'sd128);
    a = make_matrix(2, 3, 21);
    run_op("transpose", OP_TRANSPOSE, a, b, '0, 6);
    check_stream("transpose", OP_TRANSPOSE, a, b, '0);
  endtask

  task automatic mat_mul_backpressure();
    matrix_t     a;
    matrix_t     b;
    acc_t        fast[$];
    logic [31:0] fast_cycles;
    int          idx;
    a          = rand_matrix(3, 4);
    b          = rand_matrix(4, 2);
    rand_ready = 1'b0;
    run_op("matmul ready high", OP_MAT_MUL, a, b, '0, 6);
    check_stream("matmul ready high", OP_MAT_MUL, a, b, '0);
    fast        = got_data;
    fast_cycles = run_cycles;
    rand_ready  = 1'b1;
    run_op("matmul back-pressure", OP_MAT_MUL, a, b, '0, 6);
    rand_ready  = 1'b0;
    check_stream("matmul back-pressure", OP_MAT_MUL, a, b, '0);
    for (idx = 0; idx < fast.size() && idx < got_data.size(); idx++) begin
      check_value($sformatf("matmul order %0d", idx), longint'(fast[idx]),
                  longint'(got_data[idx]));
    end
    // Each stalled cycle adds at least one cycle
    check_cnt++;
    if (longint'(run_cycles) < longint'(fast_cycles) + longint'(stall_cnt)) begin
      err_cnt++;
      $display("Cycle count %0d under back-pressure is short of %0d plus %0d stall cycles",
               run_cycles, fast_cycles, stall_cnt);
    end
  endtask

  task automatic dim_errors();
    matrix_t a;
    matrix_t b;
    a = make_matrix(3, 2, 5);
    b = make_matrix(2, 3, 9);
    run_op("add shape error", OP_ADD, a, b, '0, 0);
    check_value("add shape error flag", 1, longint'(error_o));
    a = make_matrix(3, 4, 1);
    b = make_matrix(3, 2, 2);
    run_op("matmul shape error", OP_MAT_MUL, a, b, '0, 0);
    check_value("matmul shape error flag", 1, longint'(error_o));
    // A valid op clears the flag
    a = make_matrix(2, 2, 3);
    b = make_matrix(2, 2, -7);
    run_op("add after error", OP_ADD, a, b, '0, 4);
    check_stream("add after error", OP_ADD, a, b, '0);
    check_value("add after error flag", 0, longint'(error_o));
  endtask

// ==== dv/mat_alu_tb.sv ====
// Matrix ALU testbench
// Clock, reset, DUT, LFSR ready source, value checks and bounded
// waits; the directed tests come from the included test file
`timescale 1ns/100ps

module mat_alu_tb
  import mat_alu_pkg::*;
();

  // Cycle limit for any single wait
  localparam int TIMEOUT_CYC = 100;

  logic        clk;
  logic        rst_n;
  logic        start_i;
  op_code_t    op_code_i;
  matrix_t     mat_a_i;
  matrix_t     mat_b_i;
  elem_t       scalar_i;
  logic        stream_ready_i;
  logic        done_o;
  logic        error_o;
  logic [31:0] cycle_cnt_o;
  logic        stream_valid_o;
  logic        stream_last_col_o;
  acc_t        stream_data_o;

  int          err_cnt;
  int          check_cnt;
  int          timeout_cnt;
  logic [15:0] lfsr_q;
  // Ready from LFSR when set, held high otherwise
  logic        rand_ready;

  // Stream collected by the last run
  acc_t        got_data[$];
  logic        got_last[$];
  int          stall_cnt;
  logic [31:0] run_cycles;

  mat_alu_top u_mat_alu_top (
    .clk               (clk),
    .rst_n             (rst_n),
    .start_i           (start_i),
    .op_code_i         (op_code_i),
    .mat_a_i           (mat_a_i),
    .mat_b_i           (mat_b_i),
    .scalar_i          (scalar_i),
    .stream_ready_i    (stream_ready_i),
    .done_o            (done_o),
    .error_o           (error_o),
    .cycle_cnt_o       (cycle_cnt_o),
    .stream_valid_o    (stream_valid_o),
    .stream_last_col_o (stream_last_col_o),
    .stream_data_o     (stream_data_o)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  task automatic check_value(input string name, input longint exp, input longint act);
    check_cnt++;
    if (exp != act) begin
      err_cnt++;
      $display("Error in %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    timeout_cnt++;
    err_cnt++;
    $display("Timeout in %s: %s", name, what);
  endtask

  // Sample at negedge, a transfer happens on the next rising edge
  task automatic collect(input string name, input int count);
    int   n;
    logic held;
    acc_t held_data;
    n         = 0;
    held      = 1'b0;
    held_data = '0;
    stall_cnt = 0;
    got_data.delete();
    got_last.delete();
    while (got_data.size() < count && n < TIMEOUT_CYC) begin
      @(posedge clk);
      #2;
      stream_ready_i = rand_ready ? lfsr_bit() : 1'b1;
      @(negedge clk);
      n++;
      if (stream_valid_o) begin
        // Payload must not move while ready is low
        if (held) begin
          check_value({name, " held data"}, longint'(held_data), longint'(stream_data_o));
        end
        if (stream_ready_i) begin
          got_data.push_back(stream_data_o);
          got_last.push_back(stream_last_col_o);
          held = 1'b0;
          n    = 0;
        end else begin
          held      = 1'b1;
          held_data = stream_data_o;
          stall_cnt++;
        end
      end
    end
    if (got_data.size() < count) begin
      report_timeout(name, "waited too long for a stream element");
    end
  endtask

  // No element may show up while waiting for done
  task automatic wait_done(input string name);
    int n;
    n = 0;
    while (!done_o && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
      if (stream_valid_o) begin
        err_cnt++;
        $display("Unexpected stream element in %s before done", name);
      end
    end
    if (!done_o) begin
      report_timeout(name, "done never rose");
    end
  endtask

  task automatic run_op(input string name, input op_code_t op, input matrix_t a,
                        input matrix_t b, input elem_t s, input int count);
    int n;
    @(posedge clk);
    #2;
    op_code_i = op;
    mat_a_i   = a;
    mat_b_i   = b;
    scalar_i  = s;
    start_i   = 1'b1;
    collect(name, count);
    wait_done(name);
    run_cycles = cycle_cnt_o;
    @(posedge clk);
    #2;
    start_i = 1'b0;
    // Done drops once start is seen low
    n = 0;
    while (done_o && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (done_o) begin
      report_timeout(name, "done stayed high after start was released");
    end
  endtask

  `include "mat_alu_tests.svh"

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    err_cnt        = 0;
    check_cnt      = 0;
    timeout_cnt    = 0;
    lfsr_q         = 16'd38127;
    rand_ready     = 1'b0;
    rst_n          = 1'b0;
    start_i        = 1'b0;
    op_code_i      = OP_ADD;
    mat_a_i        = '0;
    mat_b_i        = '0;
    scalar_i       = '0;
    stream_ready_i = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_after_reset();
    add_3x2();
    scale_and_transpose();
    mat_mul_backpressure();
    dim_errors();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== hw/mat_alu_top.sv ====
// Streaming matrix ALU top level
// Add, scalar multiply, transpose and matrix product on two small
// signed matrices; results stream out row-major on valid/ready
`timescale 1ns/100ps

module mat_alu_top
  import mat_alu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  op_code_t    op_code_i,
  input  matrix_t     mat_a_i,
  input  matrix_t     mat_b_i,
  input  elem_t       scalar_i,
  input  logic        stream_ready_i,
  output logic        done_o,
  output logic        error_o,
  output logic [31:0] cycle_cnt_o,
  output logic        stream_valid_o,
  output logic        stream_last_col_o,
  output acc_t        stream_data_o
);

  // Datapath result strobe and payload
  logic res_valid;
  logic res_last_col;
  acc_t res_data;

  // Element accepted downstream
  logic tx_done;

  // Step bus from sequencer to datapath
  mat_elem_if u_elem_if ();

  mat_op_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .op_code_i   (op_code_i),
    .a_rows_i    (mat_a_i.rows),
    .a_cols_i    (mat_a_i.cols),
    .b_rows_i    (mat_b_i.rows),
    .b_cols_i    (mat_b_i.cols),
    .tx_done_i   (tx_done),
    .elem        (u_elem_if.ctrl),
    .done_o      (done_o),
    .error_o     (error_o),
    .cycle_cnt_o (cycle_cnt_o)
  );

  mat_elem_datapath u_datapath (
    .clk            (clk),
    .rst_n          (rst_n),
    .mat_a_i        (mat_a_i),
    .mat_b_i        (mat_b_i),
    .scalar_i       (scalar_i),
    .elem           (u_elem_if.dp),
    .res_valid_o    (res_valid),
    .res_last_col_o (res_last_col),
    .res_data_o     (res_data)
  );

  mat_stream_out u_stream (
    .clk               (clk),
    .rst_n             (rst_n),
    .res_valid_i       (res_valid),
    .res_last_col_i    (res_last_col),
    .res_data_i        (res_data),
    .stream_ready_i    (stream_ready_i),
    .stream_valid_o    (stream_valid_o),
    .stream_last_col_o (stream_last_col_o),
    .stream_data_o     (stream_data_o),
    .tx_done_o         (tx_done)
  );

endmodule

// ==== hw/mat_stream_out.sv ====
// Result stream output stage
// Holds one result element on a valid/ready stream until it is
// taken, then strobes tx_done back to the sequencer
`timescale 1ns/100ps

module mat_stream_out
  import mat_alu_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic res_valid_i,
  input  logic res_last_col_i,
  input  acc_t res_data_i,
  input  logic stream_ready_i,
  output logic stream_valid_o,
  output logic stream_last_col_o,
  output acc_t stream_data_o,
  output logic tx_done_o
);

  // Transfer happens when both sides agree
  assign tx_done_o = stream_valid_o && stream_ready_i;

  // ------------------------------------------------------------
  // Valid flag
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stream_valid_o <= 1'b0;
    end else if (res_valid_i) begin
      // Results arrive only while empty
      stream_valid_o <= 1'b1;
    end else if (tx_done_o) begin
      stream_valid_o <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // Payload, stable while waiting on ready
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (res_valid_i) begin
      stream_data_o     <= res_data_i;
      stream_last_col_o <= res_last_col_i;
    end
  end

endmodule

// ==== hw/mat_elem_datapath.sv ====
// Element arithmetic pipeline
// Three stages: operand fetch, sum/product/pass, then write or
// accumulate; a result leaves on the step flagged last_k
`timescale 1ns/100ps

module mat_elem_datapath
  import mat_alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  matrix_t  mat_a_i,
  input  matrix_t  mat_b_i,
  input  elem_t    scalar_i,
  mat_elem_if.dp   elem,
  output logic     res_valid_o,
  output logic     res_last_col_o,
  output acc_t     res_data_o
);

  // Cell select width
  localparam int IDX_W = $clog2(MAX_DIM);

  // Fetched cells
  elem_t a_cell;
  elem_t b_cell;

  // Stage 1
  logic  s1_valid;
  step_t s1_step;
  logic  s1_first;
  logic  s1_last;
  logic  s1_last_col;
  acc_t  s1_a;
  acc_t  s1_b;

  // Stage 2
  logic  s2_valid;
  logic  s2_mac;
  logic  s2_first;
  logic  s2_last;
  logic  s2_last_col;
  acc_t  s2_val;

  // Stage 3 accumulator
  acc_t  acc_q;

  always_comb begin
    a_cell = mat_a_i.cells[elem.a_row[IDX_W-1:0]][elem.a_col[IDX_W-1:0]];
    b_cell = mat_b_i.cells[elem.b_row[IDX_W-1:0]][elem.b_col[IDX_W-1:0]];
  end

  // ------------------------------------------------------------
  // Control pipe, one entry per issued step
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      s2_valid    <= 1'b0;
      res_valid_o <= 1'b0;
    end else begin
      s1_valid    <= elem.issue;
      s2_valid    <= s1_valid;
      // Only the closing step of an element produces output
      res_valid_o <= s2_valid && s2_last;
    end
  end

  // ------------------------------------------------------------
  // Data stages
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    // Fetch, sign-extended to full width
    s1_step     <= elem.step;
    s1_first    <= elem.first_k;
    s1_last     <= elem.last_k;
    s1_last_col <= elem.last_col;
    s1_a        <= acc_t'(a_cell);
    // Scale takes the scalar, the rest take B
    s1_b        <= (elem.step == STEP_SCALE) ? acc_t'(scalar_i) : acc_t'(b_cell);

    // Sum, product or pass
    s2_mac      <= (s1_step == STEP_MAC);
    s2_first    <= s1_first;
    s2_last     <= s1_last;
    s2_last_col <= s1_last_col;
    case (s1_step)
      STEP_SUM:  s2_val <= s1_a + s1_b;
      STEP_MOVE: s2_val <= s1_a;
      default:   s2_val <= s1_a * s1_b;
    endcase

    // Write or accumulate
    if (s2_valid) begin
      if (s2_mac) begin
        acc_q <= (s2_first ? '0 : acc_q) + s2_val;
      end else begin
        acc_q <= s2_val;
      end
      res_last_col_o <= s2_last_col;
    end
  end

  assign res_data_o = acc_q;

endmodule

// ==== hw/mat_op_ctrl.sv ====
// Matrix operation sequencer
// Accepts start, checks the shapes for the op code, then walks the
// result row-major and issues one step per element, or K MAC steps
// for a product; waits for each element to leave the stream stage
// Reports done, a dimension error and the cycle count
`timescale 1ns/100ps

module mat_op_ctrl
  import mat_alu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  op_code_t        op_code_i,
  input  dim_t            a_rows_i,
  input  dim_t            a_cols_i,
  input  dim_t            b_rows_i,
  input  dim_t            b_cols_i,
  input  logic            tx_done_i,
  mat_elem_if.ctrl        elem,
  output logic            done_o,
  output logic            error_o,
  output logic [31:0]     cycle_cnt_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_DONE
  } state_t;

  state_t      state;
  op_code_t    op_q;

  // Walk counters and their last values
  dim_t        row_cnt;
  dim_t        col_cnt;
  dim_t        k_cnt;
  dim_t        row_end;
  dim_t        col_end;
  dim_t        k_end;

  logic [31:0] cyc_q;

  // Start-time decode
  logic        op_known;
  logic        dim_err;
  dim_t        row_lim;
  dim_t        col_lim;
  dim_t        k_lim;

  // A size must lie in 1..MAX_DIM
  function automatic logic dim_ok(input dim_t d);
    return (d != '0) && (d <= dim_t'(MAX_DIM));
  endfunction

  // ------------------------------------------------------------
  // Shape check and loop limits
  // ------------------------------------------------------------
  always_comb begin
    op_known = 1'b1;
    dim_err  = 1'b0;
    row_lim  = a_rows_i;
    col_lim  = a_cols_i;
    k_lim    = dim_t'(1);
    case (op_code_i)
      OP_ADD: begin
        dim_err = (a_rows_i != b_rows_i) || (a_cols_i != b_cols_i);
      end
      OP_SCALAR_MUL: begin
        // Shape of A, no check against B
        dim_err = 1'b0;
      end
      OP_TRANSPOSE: begin
        row_lim = a_cols_i;
        col_lim = a_rows_i;
      end
      OP_MAT_MUL: begin
        dim_err = (a_cols_i != b_rows_i) || !dim_ok(b_cols_i);
        col_lim = b_cols_i;
        // Common dimension
        k_lim   = a_cols_i;
      end
      default: begin
        op_known = 1'b0;
      end
    endcase
    if (!dim_ok(a_rows_i) || !dim_ok(a_cols_i)) begin
      dim_err = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Sequencer FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      op_q    <= OP_ADD;
      row_cnt <= '0;
      col_cnt <= '0;
      k_cnt   <= '0;
      row_end <= '0;
      col_end <= '0;
      k_end   <= '0;
      error_o <= 1'b0;
      cyc_q   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start_i) begin
            op_q    <= op_code_i;
            // Unused op codes finish without error
            error_o <= op_known && dim_err;
            cyc_q   <= '0;
            row_cnt <= '0;
            col_cnt <= '0;
            k_cnt   <= '0;
            row_end <= row_lim - dim_t'(1);
            col_end <= col_lim - dim_t'(1);
            k_end   <= k_lim - dim_t'(1);
            state   <= (op_known && !dim_err) ? ST_ISSUE : ST_DONE;
          end
        end
        ST_ISSUE: begin
          cyc_q <= cyc_q + 32'd1;
          // One step per cycle until the last k
          if (k_cnt == k_end) begin
            k_cnt <= '0;
            state <= ST_WAIT;
          end else begin
            k_cnt <= k_cnt + dim_t'(1);
          end
        end
        ST_WAIT: begin
          cyc_q <= cyc_q + 32'd1;
          if (tx_done_i) begin
            if (col_cnt == col_end) begin
              col_cnt <= '0;
              if (row_cnt == row_end) begin
                state <= ST_DONE;
              end else begin
                row_cnt <= row_cnt + dim_t'(1);
                state   <= ST_ISSUE;
              end
            end else begin
              col_cnt <= col_cnt + dim_t'(1);
              state   <= ST_ISSUE;
            end
          end
        end
        ST_DONE: begin
          // Hold done until start drops
          if (!start_i) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Step bus, index mapping per op
  // ------------------------------------------------------------
  always_comb begin
    elem.issue    = (state == ST_ISSUE);
    elem.first_k  = (k_cnt == '0);
    elem.last_k   = (k_cnt == k_end);
    elem.last_col = (col_cnt == col_end);
    elem.step     = STEP_MOVE;
    elem.a_row    = row_cnt;
    elem.a_col    = col_cnt;
    elem.b_row    = row_cnt;
    elem.b_col    = col_cnt;
    case (op_q)
      OP_ADD:        elem.step = STEP_SUM;
      OP_SCALAR_MUL: elem.step = STEP_SCALE;
      OP_TRANSPOSE: begin
        // Result (i,j) reads A (j,i)
        elem.a_row = col_cnt;
        elem.a_col = row_cnt;
      end
      OP_MAT_MUL: begin
        elem.step  = STEP_MAC;
        elem.a_col = k_cnt;
        elem.b_row = k_cnt;
      end
      default: elem.step = STEP_MOVE;
    endcase
  end

  assign done_o      = (state == ST_DONE);
  assign cycle_cnt_o = cyc_q;

endmodule

// ==== hw/mat_elem_if.sv ====
// Element step bus
// Carries one issued step from the operation sequencer to the
// arithmetic pipeline, with the cells to read and the k flags
`timescale 1ns/100ps

interface mat_elem_if
  import mat_alu_pkg::*;
();

  // Marks a valid step, one cycle per step
  logic  issue;
  step_t step;

  // Cells to read, already swapped or k-indexed by the sequencer
  dim_t  a_row;
  dim_t  a_col;
  dim_t  b_row;
  dim_t  b_col;

  // Clear accumulator on this step
  logic  first_k;
  // Emit result after this step
  logic  last_k;
  // Produced element closes its row
  logic  last_col;

  modport ctrl (
    output issue, step, a_row, a_col, b_row, b_col, first_k, last_k, last_col
  );

  modport dp (
    input  issue, step, a_row, a_col, b_row, b_col, first_k, last_k, last_col
  );

endinterface

// ==== hw/mat_alu_pkg.sv ====
// Matrix ALU shared definitions
// Sizes, element and result types, the matrix container,
// op codes and the step codes the datapath executes
package mat_alu_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------
  // Largest row or column count
  parameter int MAX_DIM = 4;
  // Matrix element width
  parameter int ELEM_W  = 8;
  // Result and accumulator width
  parameter int ACC_W   = 32;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  // Row count, column count or index, must reach MAX_DIM itself
  typedef logic [$clog2(MAX_DIM+1)-1:0] dim_t;

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // Only the top-left rows x cols corner holds data
  typedef struct packed {
    dim_t                                  rows;
    dim_t                                  cols;
    elem_t [MAX_DIM-1:0][MAX_DIM-1:0]      cells;
  } matrix_t;

  // Codes 4 to 7 are unused
  typedef enum logic [2:0] {
    OP_ADD        = 3'd0,
    OP_SCALAR_MUL = 3'd1,
    OP_TRANSPOSE  = 3'd2,
    OP_MAT_MUL    = 3'd3
  } op_code_t;

  // One datapath step
  typedef enum logic [1:0] {
    STEP_SUM   = 2'd0,  // A cell plus B cell
    STEP_SCALE = 2'd1,  // A cell times scalar
    STEP_MOVE  = 2'd2,  // A cell passed through
    STEP_MAC   = 2'd3   // A cell times B cell, accumulated
  } step_t;

endpackage
